// ==== hw/ptw_dmem_pkg.sv ====
// --------------------------------------------------
// PTW to data-cache bridge shared definitions
// Widths, walker command codes and port structs
// --------------------------------------------------
package ptw_dmem_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int unsigned PADDR_W      = 40;
    localparam int unsigned WORD_W       = 64;
    localparam int unsigned BYTE_EN_W    = WORD_W / 8;    // Byte enables per word
    localparam int unsigned DC_REQ_WORDS = 2;             // Words per request line
    localparam int unsigned LINE_W       = DC_REQ_WORDS * WORD_W;
    localparam int unsigned WORD_IDX_W   = $clog2(DC_REQ_WORDS);
    localparam int unsigned OFFSET_W     = 4;             // Byte offset in a line
    localparam int unsigned SET_W        = 6;
    localparam int unsigned TAG_W        = PADDR_W - OFFSET_W - SET_W;
    localparam int unsigned CMD_W        = 5;
    localparam int unsigned TYP_W        = 3;
    localparam int unsigned LAT_W        = 8;             // PMU latency event

    // Walker memory command that maps to an atomic OR
    localparam logic [CMD_W-1:0] CMD_AMO_OR = 5'b01010;

    // --------------------------------------------------
    // Cache operation
    // --------------------------------------------------
    typedef enum logic {
        DC_OP_LOAD   = 1'b0,
        DC_OP_AMO_OR = 1'b1
    } dc_op_e;

    // --------------------------------------------------
    // Walker side
    // --------------------------------------------------
    typedef struct packed {
        logic [PADDR_W-1:0] addr;
        logic [CMD_W-1:0]   cmd;
        logic [TYP_W-1:0]   typ;     // Access size code
        logic [WORD_W-1:0]  data;
    } ptw_req_t;

    // --------------------------------------------------
    // Cache side
    // --------------------------------------------------

    // One request line, seen flat or per word lane
    typedef union packed {
        logic [LINE_W-1:0]                   flat;
        logic [DC_REQ_WORDS-1:0][WORD_W-1:0] words;
    } dc_line_u;

    typedef logic [DC_REQ_WORDS-1:0][BYTE_EN_W-1:0] dc_be_t;

    typedef struct packed {
        logic [OFFSET_W+SET_W-1:0] addr_offset;   // Set index and line offset
        logic [TAG_W-1:0]          addr_tag;
        dc_op_e                    op;
        logic [TYP_W-1:0]          size;
        dc_line_u                  wdata;
        dc_be_t                    be;
    } dc_req_t;

    typedef struct packed {
        dc_line_u rdata;
    } dc_rsp_t;

endpackage

// ==== hw/ptw_port_fsm.sv ====
// --------------------------------------------------
// Walker port sequencer
// Accept, issue to the cache, wait for the response
// --------------------------------------------------
module ptw_port_fsm (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic ptw_req_valid_i,
    input  logic dc_req_ready_i,
    input  logic dc_rsp_valid_i,
    output logic ptw_req_ready_o,
    output logic accept_o,
    output logic issue_o,
    output logic done_o,
    output logic pmu_access_o
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ISSUE = 2'd1,
        WAIT  = 2'd2
    } state_e;

    state_e state_q;
    state_e state_d;

    // --------------------------------------------------
    // Handshake decode
    // --------------------------------------------------
    assign ptw_req_ready_o = (state_q == IDLE);
    assign accept_o        = ptw_req_valid_i & ptw_req_ready_o;
    assign issue_o         = (state_q == ISSUE);          // Cache request valid
    assign done_o          = (state_q == WAIT) & dc_rsp_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept_o) begin
                    state_d = ISSUE;
                end
            end
            ISSUE: begin
                if (dc_req_ready_i) begin     // Held here under back-pressure
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (dc_rsp_valid_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= IDLE;
            pmu_access_o <= 1'b0;
        end else begin
            state_q      <= state_d;
            pmu_access_o <= accept_o;    // One pulse per walker access
        end
    end

endmodule

// ==== hw/ptw_req_packer.sv ====
// --------------------------------------------------
// Walker request capture and cache request formatting
// --------------------------------------------------
module ptw_req_packer (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                accept_i,
    input  ptw_dmem_pkg::ptw_req_t              ptw_req_i,
    output ptw_dmem_pkg::dc_req_t               dc_req_o,
    output logic [ptw_dmem_pkg::WORD_IDX_W-1:0] word_idx_o
);
    import ptw_dmem_pkg::*;

    ptw_req_t req_q;    // Held for the whole access
    logic     is_amo;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q <= '0;
        end else if (accept_i) begin
            req_q <= ptw_req_i;
        end
    end

    assign is_amo = (req_q.cmd == CMD_AMO_OR);

    // Lane is the word address bit just above the byte offset in a word
    assign word_idx_o = req_q.addr[OFFSET_W-1 -: WORD_IDX_W];

    // --------------------------------------------------
    // Request fields
    // --------------------------------------------------
    always_comb begin
        dc_req_o.addr_offset = req_q.addr[OFFSET_W+SET_W-1:0];
        dc_req_o.addr_tag    = req_q.addr[PADDR_W-1:OFFSET_W+SET_W];
        dc_req_o.op          = is_amo ? DC_OP_AMO_OR : DC_OP_LOAD;
        dc_req_o.size        = req_q.typ;

        for (int i = 0; i < DC_REQ_WORDS; i++) begin
            if (word_idx_o == WORD_IDX_W'(i)) begin
                dc_req_o.wdata.words[i] = req_q.data;
                dc_req_o.be[i]          = {BYTE_EN_W{is_amo}};   // Loads write nothing
            end else begin
                dc_req_o.wdata.words[i] = '0;
                dc_req_o.be[i]          = '0;
            end
        end
    end

endmodule

// ==== hw/ptw_rsp_selector.sv ====
// --------------------------------------------------
// Response word select and register for the walker
// --------------------------------------------------
module ptw_rsp_selector (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                done_i,
    input  logic [ptw_dmem_pkg::WORD_IDX_W-1:0] word_idx_i,
    input  ptw_dmem_pkg::dc_rsp_t               dc_rsp_i,
    output logic                                ptw_rsp_valid_o,
    output logic [ptw_dmem_pkg::WORD_W-1:0]     ptw_rsp_data_o
);
    import ptw_dmem_pkg::*;

    logic [WORD_W-1:0] rsp_word;

    // Same lane the store data went to
    assign rsp_word = dc_rsp_i.rdata.words[word_idx_i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptw_rsp_valid_o <= 1'b0;
        end else begin
            ptw_rsp_valid_o <= done_i;    // Follows the one-cycle done pulse
        end
    end

    always_ff @(posedge clk_i) begin
        if (done_i) begin
            ptw_rsp_data_o <= rsp_word;
        end
    end

endmodule

// ==== hw/ptw_latency_counter.sv ====
// --------------------------------------------------
// Walker access latency counter for the PMU
// --------------------------------------------------
module ptw_latency_counter (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           accept_i,
    input  logic                           done_i,
    output logic [ptw_dmem_pkg::LAT_W-1:0] pmu_lat_o
);
    import ptw_dmem_pkg::*;

    logic [LAT_W-1:0] cnt_q;
    logic [LAT_W-1:0] cnt_inc;
    logic             open_q;     // Access in flight

    // Saturating increment
    assign cnt_inc = (cnt_q == {LAT_W{1'b1}}) ? cnt_q : cnt_q + 1'b1;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q     <= '0;
            open_q    <= 1'b0;
            pmu_lat_o <= '0;
        end else begin
            if (accept_i) begin
                cnt_q  <= '0;
                open_q <= 1'b1;
            end else if (open_q) begin
                cnt_q <= cnt_inc;
            end

            // Response edge counts too
            if (done_i) begin
                open_q    <= 1'b0;
                pmu_lat_o <= cnt_inc;
            end
        end
    end

endmodule

// ==== hw/ptw_dmem_bridge.sv ====
// --------------------------------------------------
// PTW memory port to data-cache requester bridge
// --------------------------------------------------
module ptw_dmem_bridge (
    input  logic                               clk_i,
    input  logic                               arst_n_i,

    // Walker port
    input  logic                               ptw_req_valid_i,
    input  ptw_dmem_pkg::ptw_req_t             ptw_req_i,
    output logic                               ptw_req_ready_o,
    output logic                               ptw_rsp_valid_o,
    output logic [ptw_dmem_pkg::WORD_W-1:0]    ptw_rsp_data_o,

    // Data-cache requester port
    output logic                               dc_req_valid_o,
    output ptw_dmem_pkg::dc_req_t              dc_req_o,
    input  logic                               dc_req_ready_i,
    input  logic                               dc_rsp_valid_i,
    input  ptw_dmem_pkg::dc_rsp_t              dc_rsp_i,

    // PMU events
    output logic                               pmu_access_o,
    output logic [ptw_dmem_pkg::LAT_W-1:0]     pmu_lat_o
);
    import ptw_dmem_pkg::*;

    logic                  accept;
    logic                  done;
    logic [WORD_IDX_W-1:0] word_idx;   // Lane of the current access

    ptw_port_fsm ptw_port_fsm_inst (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .ptw_req_valid_i (ptw_req_valid_i),
        .dc_req_ready_i  (dc_req_ready_i),
        .dc_rsp_valid_i  (dc_rsp_valid_i),
        .ptw_req_ready_o (ptw_req_ready_o),
        .accept_o        (accept),
        .issue_o         (dc_req_valid_o),
        .done_o          (done),
        .pmu_access_o    (pmu_access_o)
    );

    ptw_req_packer ptw_req_packer_inst (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .accept_i   (accept),
        .ptw_req_i  (ptw_req_i),
        .dc_req_o   (dc_req_o),
        .word_idx_o (word_idx)
    );

    ptw_rsp_selector ptw_rsp_selector_inst (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .done_i          (done),
        .word_idx_i      (word_idx),
        .dc_rsp_i        (dc_rsp_i),
        .ptw_rsp_valid_o (ptw_rsp_valid_o),
        .ptw_rsp_data_o  (ptw_rsp_data_o)
    );

    ptw_latency_counter ptw_latency_counter_inst (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .accept_i  (accept),
        .done_i    (done),
        .pmu_lat_o (pmu_lat_o)
    );

endmodule

// ==== verification/ptw_dmem_bridge_assert.sv ====
// --------------------------------------------------
// Protocol assertions on the bridge walker and cache ports
// --------------------------------------------------
module ptw_dmem_bridge_assert (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  dc_req_valid_i,
    input  logic                  dc_req_ready_i,
    input  ptw_dmem_pkg::dc_req_t dc_req_i,
    input  logic                  ptw_req_ready_i,
    input  logic                  ptw_rsp_valid_i
);

    int unsigned fail_cnt = 0;

    // --------------------------------------------------
    // Cache request port
    // --------------------------------------------------

    // Stalled request stays put
    req_stable_a: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (dc_req_valid_i && !dc_req_ready_i) |=> (dc_req_valid_i && $stable(dc_req_i))
    ) else begin
        fail_cnt++;
        $error("dc_req_o changed or dropped valid under back-pressure");
    end

    // Walker is never accepted while a cache request is pending
    ready_excl_a: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !(ptw_req_ready_i && dc_req_valid_i)
    ) else begin
        fail_cnt++;
        $error("ptw_req_ready_o high together with dc_req_valid_o");
    end

    // --------------------------------------------------
    // Walker response port
    // --------------------------------------------------
    rsp_pulse_a: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        ptw_rsp_valid_i |=> !ptw_rsp_valid_i
    ) else begin
        fail_cnt++;
        $error("ptw_rsp_valid_o held longer than one cycle");
    end

endmodule

// ==== verification/tb_ptw_dmem_bridge.sv ====
// --------------------------------------------------
// Random-stimulus testbench for the PTW to D$ bridge
// Cache responder, reference model and checks
// --------------------------------------------------
module tb_ptw_dmem_bridge;
    import ptw_dmem_pkg::*;

    localparam int unsigned     CLK_PERIOD = 20;
    localparam int unsigned     NUM_ACCESS = 400;
    localparam int unsigned     MAX_CYCLES = 300;    // Per access, long delays included
    localparam longint unsigned WATCHDOG_T = 64'(NUM_ACCESS) * MAX_CYCLES * CLK_PERIOD;
    localparam int unsigned     RAND_SEED  = 32'hc46ef064;
    localparam int unsigned     LAT_MAX    = 255;
    localparam int unsigned     CHK_W      = $bits(dc_req_t);    // Widest compared value

    logic              clk;
    logic              arst_n;
    logic              ptw_req_valid;
    ptw_req_t          ptw_req;
    logic              ptw_req_ready;
    logic              ptw_rsp_valid;
    logic [WORD_W-1:0] ptw_rsp_data;
    logic              dc_req_valid;
    dc_req_t           dc_req;
    logic              dc_req_ready;
    logic              dc_rsp_valid;
    dc_rsp_t           dc_rsp;
    logic              pmu_access;
    logic [LAT_W-1:0]  pmu_lat;

    int unsigned     err_cnt       = 0;
    int unsigned     chk_cnt       = 0;
    int unsigned     rsp_pulses    = 0;
    int unsigned     access_pulses = 0;
    int unsigned     sat_cnt       = 0;    // Accesses that hit the latency cap
    longint unsigned cycle_cnt     = 0;    // Rising edges since time zero

    ptw_dmem_bridge ptw_dmem_bridge_inst (
        .clk_i           (clk),
        .arst_n_i        (arst_n),
        .ptw_req_valid_i (ptw_req_valid),
        .ptw_req_i       (ptw_req),
        .ptw_req_ready_o (ptw_req_ready),
        .ptw_rsp_valid_o (ptw_rsp_valid),
        .ptw_rsp_data_o  (ptw_rsp_data),
        .dc_req_valid_o  (dc_req_valid),
        .dc_req_o        (dc_req),
        .dc_req_ready_i  (dc_req_ready),
        .dc_rsp_valid_i  (dc_rsp_valid),
        .dc_rsp_i        (dc_rsp),
        .pmu_access_o    (pmu_access),
        .pmu_lat_o       (pmu_lat)
    );

    bind ptw_dmem_bridge ptw_dmem_bridge_assert ptw_dmem_bridge_assert_inst (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .dc_req_valid_i  (dc_req_valid_o),
        .dc_req_ready_i  (dc_req_ready_i),
        .dc_req_i        (dc_req_o),
        .ptw_req_ready_i (ptw_req_ready_o),
        .ptw_rsp_valid_i (ptw_rsp_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Pulses are one cycle wide, so each is seen at exactly one falling edge
    always @(negedge clk) begin
        if (arst_n && ptw_rsp_valid) begin
            rsp_pulses++;
        end
        if (arst_n && pmu_access) begin
            access_pulses++;
        end
    end

    initial begin
        #(WATCHDOG_T);
        $display("Timeout: the run did not finish within %0d time units", WATCHDOG_T);
        $display("SIMULATION FAILED");
        $finish;
    end

    // --------------------------------------------------
    // Checker and reference model
    // --------------------------------------------------
    task automatic check_eq(input logic [CHK_W-1:0] actual,
                            input logic [CHK_W-1:0] expected, input string what);
        chk_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    function automatic ptw_req_t random_req();
        ptw_req_t r;
        r.addr = PADDR_W'({$urandom(), $urandom()});
        r.typ  = TYP_W'($urandom());
        r.data = {$urandom(), $urandom()};
        if ($urandom_range(1, 0) == 1) begin
            r.cmd = CMD_AMO_OR;
        end else begin
            r.cmd = CMD_W'($urandom());    // May still hit the AMO code
        end
        return r;
    endfunction

    function automatic logic [LINE_W-1:0] random_line();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // Store data goes to the lane picked by address bit 3
    function automatic logic [LINE_W-1:0] expected_wdata(input ptw_req_t r);
        logic [LINE_W-1:0] line;
        line = '0;
        if (r.addr[3]) begin
            line[127:64] = r.data;
        end else begin
            line[63:0] = r.data;
        end
        return line;
    endfunction

    function automatic logic [15:0] expected_be(input ptw_req_t r);
        logic [15:0] be;
        be = '0;
        if (r.cmd == 5'b01010) begin
            if (r.addr[3]) begin
                be[15:8] = 8'hff;
            end else begin
                be[7:0] = 8'hff;
            end
        end
        return be;
    endfunction

    task automatic check_request(input ptw_req_t r);
        check_eq(dc_req.addr_offset, r.addr[9:0], "dc_req_o.addr_offset");
        check_eq(dc_req.addr_tag, r.addr[39:10], "dc_req_o.addr_tag");
        check_eq(dc_req.size, r.typ, "dc_req_o.size");
        check_eq(dc_req.op, (r.cmd == 5'b01010) ? 1'b1 : 1'b0, "dc_req_o.op");
        check_eq(dc_req.wdata.flat, expected_wdata(r), "dc_req_o.wdata");
        check_eq(dc_req.be, expected_be(r), "dc_req_o.be");
    endtask

    task automatic check_reset_state();
        check_eq(ptw_req_ready, 1'b1, "ptw_req_ready_o after reset");
        check_eq(dc_req_valid, 1'b0, "dc_req_valid_o after reset");
        check_eq(ptw_rsp_valid, 1'b0, "ptw_rsp_valid_o after reset");
        check_eq(pmu_access, 1'b0, "pmu_access_o after reset");
        check_eq(pmu_lat, '0, "pmu_lat_o after reset");
    endtask

    // --------------------------------------------------
    // One walker access, entered and left on a falling edge
    // --------------------------------------------------
    task automatic run_access();
        ptw_req_t          req;
        dc_req_t           held;
        logic [LINE_W-1:0] line;
        int unsigned       gap;
        int unsigned       rdy_dly;
        int unsigned       rsp_dly;
        int unsigned       k;
        int unsigned       j;
        longint unsigned   e0;
        longint unsigned   lat;

        req     = random_req();
        line    = random_line();
        gap     = $urandom_range(2, 0);
        rdy_dly = $urandom_range(5, 0);
        if ($urandom_range(19, 0) == 0) begin
            rsp_dly = $urandom_range(290, 256);    // Drives the counter into saturation
        end else begin
            rsp_dly = $urandom_range(8, 1);
        end

        repeat (gap) begin
            ptw_req_valid = 1'b0;
            ptw_req       = random_req();
            check_eq(ptw_req_ready, 1'b1, "ptw_req_ready_o while idle");
            @(negedge clk);
        end

        ptw_req_valid = 1'b1;
        ptw_req       = req;
        check_eq(ptw_req_ready, 1'b1, "ptw_req_ready_o before accept");
        @(negedge clk);                                // Acceptance edge passed
        e0            = cycle_cnt;
        ptw_req_valid = 1'($urandom_range(1, 0));      // Must be ignored while busy
        ptw_req       = random_req();
        check_eq(pmu_access, 1'b1, "pmu_access_o after accept");
        check_request(req);
        held = dc_req;

        // Cache stalls the request for rdy_dly cycles
        for (k = 0; k <= rdy_dly; k++) begin
            dc_req_ready = (k == rdy_dly);
            check_eq(dc_req_valid, 1'b1, "dc_req_valid_o while issuing");
            check_eq(dc_req, held, "dc_req_o under back-pressure");
            check_eq(ptw_req_ready, 1'b0, "ptw_req_ready_o while issuing");
            if (k > 0) begin
                check_eq(pmu_access, 1'b0, "pmu_access_o after its pulse");
            end
            @(negedge clk);
        end

        dc_req_ready = 1'($urandom_range(1, 0));
        for (j = 1; j <= rsp_dly; j++) begin
            dc_rsp_valid     = (j == rsp_dly);
            dc_rsp.rdata.flat = (j == rsp_dly) ? line : random_line();
            check_eq(dc_req_valid, 1'b0, "dc_req_valid_o after issue");
            check_eq(ptw_req_ready, 1'b0, "ptw_req_ready_o while waiting");
            check_eq(ptw_rsp_valid, 1'b0, "ptw_rsp_valid_o while waiting");
            @(negedge clk);
        end

        // Response edge passed
        lat = cycle_cnt - e0;
        if (lat >= LAT_MAX) begin
            lat = LAT_MAX;
            sat_cnt++;
        end
        dc_rsp_valid      = 1'b0;
        dc_rsp.rdata.flat = random_line();
        dc_req_ready      = 1'b0;
        ptw_req_valid     = 1'b0;
        check_eq(ptw_rsp_valid, 1'b1, "ptw_rsp_valid_o at response");
        check_eq(ptw_rsp_data, req.addr[3] ? line[127:64] : line[63:0], "ptw_rsp_data_o");
        check_eq(pmu_lat, LAT_W'(lat), "pmu_lat_o");
        check_eq(ptw_req_ready, 1'b1, "ptw_req_ready_o after response");
        check_eq(dc_req_valid, 1'b0, "dc_req_valid_o after response");
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int unsigned assert_fails;

        void'($urandom(RAND_SEED));
        arst_n        = 1'b0;
        ptw_req_valid = 1'b0;
        ptw_req       = '0;
        dc_req_ready  = 1'b0;
        dc_rsp_valid  = 1'b0;
        dc_rsp        = '0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_reset_state();

        repeat (NUM_ACCESS) begin
            run_access();
        end

        repeat (3) @(negedge clk);
        check_eq(rsp_pulses, NUM_ACCESS, "ptw_rsp_valid_o pulse count");
        check_eq(access_pulses, NUM_ACCESS, "pmu_access_o pulse count");
        check_eq(sat_cnt > 0, 1'b1, "saturated latency seen");

        assert_fails = ptw_dmem_bridge_inst.ptw_dmem_bridge_assert_inst.fail_cnt;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 chk_cnt, err_cnt, assert_fails);
        if (err_cnt == 0 && assert_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hw/ptw_dmem_pkg.sv
hw/ptw_port_fsm.sv
hw/ptw_req_packer.sv
hw/ptw_rsp_selector.sv
hw/ptw_latency_counter.sv
hw/ptw_dmem_bridge.sv
verification/ptw_dmem_bridge_assert.sv
verification/tb_ptw_dmem_bridge.sv

// ==== Bender.yml ====
package:
  name: ptw_dmem_bridge

sources:
  # Package first, then the leaf blocks and the top
  - files:
      - hw/ptw_dmem_pkg.sv
      - hw/ptw_port_fsm.sv
      - hw/ptw_req_packer.sv
      - hw/ptw_rsp_selector.sv
      - hw/ptw_latency_counter.sv
      - hw/ptw_dmem_bridge.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - verification/ptw_dmem_bridge_assert.sv
      - verification/tb_ptw_dmem_bridge.sv
